//--- Makefile
RTL := hw/rd_link_pkg.sv hw/link_online_sync.sv hw/ll_tx_channel.sv \
       hw/ll_rx_channel.sv hw/phy_word_map.sv hw/axi_rd_packet_master_top.sv

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --top-module axi_rd_packet_master_top $(RTL)

sim:
	verilator --binary --timing --top-module tb_top -f sources.f --Mdir obj_dir
	./obj_dir/Vtb_top > sim.log
	cat sim.log
	@if grep -q "ERRORS FOUND" sim.log; then \
	  echo "simulation failed"; \
	  exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- dv/link_checker.sv
`default_nettype none

module link_checker (
  input logic                          clk_wr,
  input logic                          rst_n,
  input logic                          hold_check_en,
  input logic [rd_link_pkg::PHY_W-1:0] tx_phy0,
  input rd_link_pkg::r_pkt_t           user_r,
  input logic                          user_rvalid,
  input logic                          user_rready
);
  timeunit 1ns;
  timeprecision 100ps;
  import rd_link_pkg::*;

  int               errors = 0;
  int               checks = 0;
  int               ar_pushes = 0;
  int               r_taken = 0;
  int               r_credits = 0;
  ar_pkt_t          ar_exp [$];
  r_pkt_t           r_exp [$];
  ar_pkt_t          next_ar;
  r_pkt_t           next_r;
  r_pkt_t           stalled_r;
  logic             taken_q;
  logic             stalled_q;
  logic [PHY_W-1:0] tx_word;
  logic [PHY_W-1:0] exp_word;

  task automatic compare(input string name, input logic [PHY_W-1:0] got,
                         input logic [PHY_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("error at %0t ns: %s", $time, what);
  endtask

  task automatic expect_ar(input ar_pkt_t pkt);
    ar_exp.push_back(pkt);
  endtask

  task automatic expect_r(input r_pkt_t pkt);
    r_exp.push_back(pkt);
  endtask

  ////////////////////////////////////////
  // Per-cycle port checks
  ////////////////////////////////////////

  always @(posedge clk_wr) begin
    if (!rst_n) begin
      taken_q   = 1'b0;
      stalled_q = 1'b0;
    end else begin
      if (tx_phy0[TX_PUSH_BIT]) begin
        ar_pushes++;
        if (ar_exp.size() == 0) begin
          report_failure("AR packet sent on tx_phy0 with no request outstanding");
        end else begin
          next_ar  = ar_exp.pop_front();
          exp_word = '0;
          exp_word[TX_PUSH_BIT] = 1'b1;
          // Packed from addr upward through burst, len, size and id
          exp_word[TX_AR_LSB +: 49] = {next_ar.id, next_ar.size, next_ar.len,
                                       next_ar.burst, next_ar.addr};
          tx_word = tx_phy0;
          tx_word[TX_RCRED_BIT] = 1'b0;
          compare("tx_phy0", tx_word, exp_word);
        end
      end
      // r-credit pulse one cycle after each R transfer
      compare("tx_phy0 r_credit", PHY_W'(tx_phy0[TX_RCRED_BIT]), PHY_W'(taken_q));
      if (tx_phy0[TX_RCRED_BIT]) begin
        r_credits++;
      end
      if (hold_check_en && stalled_q) begin
        compare("user_rvalid", PHY_W'(user_rvalid), PHY_W'(1'b1));
        compare("user_r", PHY_W'(user_r), PHY_W'(stalled_r));
      end
      taken_q   = user_rvalid && user_rready;
      stalled_q = user_rvalid && !user_rready;
      stalled_r = user_r;
      if (taken_q) begin
        r_taken++;
        if (r_exp.size() == 0) begin
          report_failure("R transfer on user_r with no packet expected");
        end else begin
          next_r = r_exp.pop_front();
          compare("user_r", PHY_W'(user_r), PHY_W'(next_r));
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- dv/tb_top.sv
`default_nettype none

module tb_top;
  timeunit 1ns;
  timeprecision 100ps;
  import rd_link_pkg::*;

  localparam int N_ENTRIES  = 6;
  localparam int LINK_DELAY = 5;
  localparam int TIMEOUT    = 200;

  // One AR request, its R response and a ready stall per row
  localparam ar_pkt_t AR_TAB [N_ENTRIES] = '{
    '{id: 4'h1, size: 3'd2, len: 8'd0,  burst: 2'd1, addr: 32'h0000_1000},
    '{id: 4'h2, size: 3'd2, len: 8'd3,  burst: 2'd1, addr: 32'h0000_2040},
    '{id: 4'h7, size: 3'd1, len: 8'd0,  burst: 2'd0, addr: 32'h8000_0002},
    '{id: 4'ha, size: 3'd2, len: 8'd7,  burst: 2'd2, addr: 32'hdead_bee0},
    '{id: 4'hf, size: 3'd0, len: 8'hff, burst: 2'd1, addr: 32'hffff_fffc},
    '{id: 4'h0, size: 3'd2, len: 8'd1,  burst: 2'd1, addr: 32'h1234_5678}
  };
  localparam r_pkt_t R_TAB [N_ENTRIES] = '{
    '{id: 4'h1, last: 1'b1, resp: 2'd0, data: 32'hcafe_0001},
    '{id: 4'h2, last: 1'b0, resp: 2'd0, data: 32'h0bad_f00d},
    '{id: 4'h7, last: 1'b1, resp: 2'd2, data: 32'h5555_aaaa},
    '{id: 4'ha, last: 1'b0, resp: 2'd1, data: 32'hffff_0000},
    '{id: 4'hf, last: 1'b1, resp: 2'd3, data: 32'h0000_ffff},
    '{id: 4'h0, last: 1'b1, resp: 2'd0, data: 32'h8765_4321}
  };
  localparam int STALL_TAB [N_ENTRIES] = '{0, 3, 1, 6, 0, 2};
  localparam r_pkt_t DROP_R = '{id: 4'h3, last: 1'b1, resp: 2'd0, data: 32'h0000_d00d};

  logic               clk_wr = 1'b0;
  logic               rst_n;
  logic               tx_online;
  logic               rx_online;
  logic [DELAY_W-1:0] delay_value;
  logic [CRED_W-1:0]  init_ar_credit;
  ar_pkt_t            user_ar;
  logic               user_arvalid;
  logic               user_arready;
  r_pkt_t             user_r;
  logic               user_rvalid;
  logic               user_rready = 1'b0;
  logic [PHY_W-1:0]   tx_phy0;
  logic [PHY_W-1:0]   rx_phy0;
  logic               hold_check_en = 1'b1;

  // Far side of the link
  logic   rx_r_push = 1'b0;
  r_pkt_t rx_r_pkt = '0;
  logic   rx_ar_cred = 1'b0;
  logic   force_rready_low = 1'b0;
  int     ar_budget = 0;
  int     ar_owed = 0;
  int     r_cred = RX_FIFO_DEPTH;
  int     stall_left = 0;
  int     seed = 25;
  r_pkt_t r_to_send [$];
  int     stall_q [$];

  axi_rd_packet_master_top axi_rd_packet_master_top_inst (.*);

  link_checker link_checker_inst (.*);

  initial begin
    forever #5 clk_wr = ~clk_wr;
  end

  always_comb begin
    rx_phy0 = '0;
    rx_phy0[RX_PUSH_BIT] = rx_r_push;
    rx_phy0[RX_R_LSB +: $bits(r_pkt_t)] = rx_r_pkt;
    rx_phy0[RX_ARCRED_BIT] = rx_ar_cred;
  end

  ////////////////////////////////////////
  // Far-side model and user_rready
  ////////////////////////////////////////

  always @(negedge clk_wr) begin
    rx_ar_cred = 1'b0;
    rx_r_push  = 1'b0;
    if (!rst_n) begin
      ar_owed     = 0;
      r_cred      = RX_FIFO_DEPTH;
      user_rready = 1'b0;
    end else begin
      // Credit goes back at least one cycle after the AR arrived
      if (ar_owed > 0 && ar_budget > 0) begin
        rx_ar_cred = 1'b1;
        ar_owed--;
        ar_budget--;
      end
      if (tx_phy0[TX_PUSH_BIT]) ar_owed++;
      if (tx_phy0[TX_RCRED_BIT]) r_cred++;
      if (r_to_send.size() > 0 && r_cred > 0) begin
        rx_r_pkt   = r_to_send.pop_front();
        stall_left = stall_q.pop_front();
        rx_r_push  = 1'b1;
        r_cred--;
      end
      if (force_rready_low) begin
        user_rready = 1'b0;
      end else if (stall_left > 0) begin
        user_rready = 1'b0;
        stall_left--;
      end else begin
        user_rready = ($random(seed) % 3) != 0;
      end
    end
  end

  task automatic finish_run();
    $display("checks %0d, errors %0d, AR pushes %0d, R transfers %0d, r-credits %0d",
             link_checker_inst.checks, link_checker_inst.errors,
             link_checker_inst.ar_pushes, link_checker_inst.r_taken,
             link_checker_inst.r_credits);
    if (link_checker_inst.errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  endtask

  task automatic give_up(input string what);
    link_checker_inst.report_failure({"timed out waiting for ", what});
    finish_run();
  endtask

  task automatic send_ar(input ar_pkt_t pkt);
    int n;
    n = 0;
    @(negedge clk_wr);
    user_ar      = pkt;
    user_arvalid = 1'b1;
    while (!user_arready) begin
      n++;
      if (n > TIMEOUT) give_up("user_arready");
      @(negedge clk_wr);
    end
    @(negedge clk_wr);
    user_arvalid = 1'b0;
  endtask

  task automatic wait_pushes(input int count);
    int n;
    n = 0;
    while (link_checker_inst.ar_pushes < count) begin
      n++;
      if (n > TIMEOUT) give_up("AR pushbits on tx_phy0");
      @(negedge clk_wr);
    end
  endtask

  task automatic wait_r_taken(input int count);
    int n;
    n = 0;
    while (link_checker_inst.r_taken < count) begin
      n++;
      if (n > TIMEOUT) give_up("R transfers on user_r");
      @(negedge clk_wr);
    end
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    int n;
    rst_n          = 1'b0;
    tx_online      = 1'b0;
    rx_online      = 1'b0;
    delay_value    = DELAY_W'(LINK_DELAY);
    init_ar_credit = CRED_W'(3);
    user_ar        = '0;
    user_arvalid   = 1'b0;
    repeat (3) @(negedge clk_wr);
    rst_n = 1'b1;
    @(negedge clk_wr);
    link_checker_inst.compare("user_arready", PHY_W'(user_arready), '0);
    link_checker_inst.compare("user_rvalid", PHY_W'(user_rvalid), '0);
    link_checker_inst.compare("tx_phy0 push", PHY_W'(tx_phy0[TX_PUSH_BIT]), '0);
    link_checker_inst.compare("tx_phy0 r_credit", PHY_W'(tx_phy0[TX_RCRED_BIT]), '0);

    // Link comes up delay_value+1 cycles after the first edge with both online
    tx_online = 1'b1;
    rx_online = 1'b1;
    n = 0;
    while (!user_arready) begin
      @(negedge clk_wr);
      n++;
      if (n > TIMEOUT) give_up("link up");
    end
    link_checker_inst.compare("link up delay", PHY_W'(n - 1), PHY_W'(LINK_DELAY + 1));

    // Three credits and no returns leave the fourth request held
    for (int i = 0; i < 4; i++) begin
      @(posedge clk_wr);
      link_checker_inst.expect_ar(AR_TAB[i]);
      send_ar(AR_TAB[i]);
    end
    repeat (20) @(negedge clk_wr);
    link_checker_inst.compare("AR pushes", PHY_W'(link_checker_inst.ar_pushes), PHY_W'(3));
    link_checker_inst.compare("user_arready", PHY_W'(user_arready), '0);
    @(posedge clk_wr);
    ar_budget = 1;
    wait_pushes(4);
    repeat (10) @(negedge clk_wr);
    link_checker_inst.compare("AR pushes", PHY_W'(link_checker_inst.ar_pushes), PHY_W'(4));

    // Table run with credits returned and random ready stalls
    @(posedge clk_wr);
    ar_budget = 1000;
    for (int i = 0; i < N_ENTRIES; i++) begin
      @(posedge clk_wr);
      link_checker_inst.expect_ar(AR_TAB[i]);
      link_checker_inst.expect_r(R_TAB[i]);
      r_to_send.push_back(R_TAB[i]);
      stall_q.push_back(STALL_TAB[i]);
      send_ar(AR_TAB[i]);
    end
    wait_pushes(4 + N_ENTRIES);
    wait_r_taken(N_ENTRIES);
    repeat (2) @(negedge clk_wr);
    link_checker_inst.compare("r-credit count", PHY_W'(link_checker_inst.r_credits),
                              PHY_W'(link_checker_inst.r_taken));

    // Link drop with a packet still waiting on user_r
    @(posedge clk_wr);
    force_rready_low = 1'b1;
    r_to_send.push_back(DROP_R);
    stall_q.push_back(0);
    n = 0;
    while (!user_rvalid) begin
      @(negedge clk_wr);
      n++;
      if (n > TIMEOUT) give_up("user_rvalid before link drop");
    end
    hold_check_en = 1'b0;
    link_checker_inst.compare("user_arready", PHY_W'(user_arready), PHY_W'(1'b1));
    rx_online = 1'b0;
    @(negedge clk_wr);
    link_checker_inst.compare("user_arready", PHY_W'(user_arready), '0);
    link_checker_inst.compare("user_rvalid", PHY_W'(user_rvalid), '0);
    finish_run();
  end

endmodule

`default_nettype wire

//--- hw/axi_rd_packet_master_top.sv
`default_nettype none

module axi_rd_packet_master_top (
  input  logic                            clk_wr,
  input  logic                            rst_n,

  // Link control
  input  logic                            tx_online,
  input  logic                            rx_online,
  input  logic [rd_link_pkg::DELAY_W-1:0] delay_value,
  input  logic [rd_link_pkg::CRED_W-1:0]  init_ar_credit,

  // User AR channel
  input  rd_link_pkg::ar_pkt_t            user_ar,
  input  logic                            user_arvalid,
  output logic                            user_arready,

  // User R channel
  output rd_link_pkg::r_pkt_t             user_r,
  output logic                            user_rvalid,
  input  logic                            user_rready,

  // PHY words
  output logic [rd_link_pkg::PHY_W-1:0]   tx_phy0,
  input  logic [rd_link_pkg::PHY_W-1:0]   rx_phy0
);
  import rd_link_pkg::*;

  logic    link_up;
  logic    tx_push;
  ar_pkt_t tx_pkt;
  logic    ar_credit;
  logic    rx_push;
  r_pkt_t  rx_pkt;
  logic    r_credit;

  link_online_sync link_online_sync_inst (
    .clk_wr      (clk_wr),
    .rst_n       (rst_n),
    .tx_online   (tx_online),
    .rx_online   (rx_online),
    .delay_value (delay_value),
    .link_up     (link_up)
  );

  ////////////////////////////////////////
  // Logic link channels
  ////////////////////////////////////////

  ll_tx_channel ll_tx_channel_ar_inst (
    .clk_wr        (clk_wr),
    .rst_n         (rst_n),
    .link_up       (link_up),
    .init_credit   (init_ar_credit),
    .user_ar       (user_ar),
    .user_arvalid  (user_arvalid),
    .user_arready  (user_arready),
    .credit_return (ar_credit),
    .tx_push       (tx_push),
    .tx_pkt        (tx_pkt)
  );

  ll_rx_channel ll_rx_channel_r_inst (
    .clk_wr      (clk_wr),
    .rst_n       (rst_n),
    .link_up     (link_up),
    .rx_push     (rx_push),
    .rx_pkt      (rx_pkt),
    .user_r      (user_r),
    .user_rvalid (user_rvalid),
    .user_rready (user_rready),
    .credit_out  (r_credit)
  );

  // PHY word packing
  phy_word_map phy_word_map_inst (
    .tx_push   (tx_push),
    .tx_pkt    (tx_pkt),
    .r_credit  (r_credit),
    .rx_phy0   (rx_phy0),
    .tx_phy0   (tx_phy0),
    .rx_push   (rx_push),
    .rx_pkt    (rx_pkt),
    .ar_credit (ar_credit)
  );

endmodule

`default_nettype wire

//--- hw/link_online_sync.sv
`default_nettype none

module link_online_sync (
  input  logic                            clk_wr,
  input  logic                            rst_n,
  input  logic                            tx_online,
  input  logic                            rx_online,
  input  logic [rd_link_pkg::DELAY_W-1:0] delay_value,
  output logic                            link_up
);
  import rd_link_pkg::*;

  sync_state_t        state;
  logic [DELAY_W-1:0] count;
  logic               both_online;

  assign both_online = tx_online && rx_online;
  assign link_up     = (state == ONLINE);

  // Either side going offline restarts the sequence
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      state <= OFFLINE;
      count <= '0;
    end else if (!both_online) begin
      state <= OFFLINE;
    end else begin
      case (state)
        OFFLINE: begin
          // First edge with both sides up
          state <= COUNTING;
          count <= delay_value;
        end
        COUNTING: begin
          if (count == '0) begin
            state <= ONLINE;
          end else begin
            count <= count - DELAY_W'(1);
          end
        end
        default: begin
          state <= ONLINE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/ll_rx_channel.sv
`default_nettype none

module ll_rx_channel (
  input  logic                 clk_wr,
  input  logic                 rst_n,
  input  logic                 link_up,
  input  logic                 rx_push,
  input  rd_link_pkg::r_pkt_t  rx_pkt,
  output rd_link_pkg::r_pkt_t  user_r,
  output logic                 user_rvalid,
  input  logic                 user_rready,
  output logic                 credit_out
);
  import rd_link_pkg::*;

  r_pkt_t            mem [RX_FIFO_DEPTH];
  // Extra MSB tells full from empty
  logic [RX_PTR_W:0] wr_ptr;
  logic [RX_PTR_W:0] rd_ptr;
  logic              empty;
  logic              full;
  logic              push;
  logic              pop;
  logic              credit_q;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[RX_PTR_W] != rd_ptr[RX_PTR_W]) &&
                 (wr_ptr[RX_PTR_W-1:0] == rd_ptr[RX_PTR_W-1:0]);

  assign push = link_up && rx_push && !full;

  // Head of queue straight to the user port
  assign user_rvalid = link_up && !empty;
  assign user_r      = mem[rd_ptr[RX_PTR_W-1:0]];
  assign pop         = user_rvalid && user_rready;

  assign credit_out = credit_q;

  always_ff @(posedge clk_wr) begin
    if (push) begin
      mem[wr_ptr[RX_PTR_W-1:0]] <= rx_pkt;
    end
  end

  ////////////////////////////////////////
  // Pointers and credit return
  ////////////////////////////////////////

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else if (!link_up) begin
      // Flush on link down
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + (RX_PTR_W + 1)'(1);
      end
      if (pop) begin
        rd_ptr <= rd_ptr + (RX_PTR_W + 1)'(1);
      end
    end
  end

  // One credit back per entry freed
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      credit_q <= 1'b0;
    end else begin
      credit_q <= pop;
    end
  end

endmodule

`default_nettype wire

//--- hw/ll_tx_channel.sv
`default_nettype none

module ll_tx_channel (
  input  logic                           clk_wr,
  input  logic                           rst_n,
  input  logic                           link_up,
  input  logic [rd_link_pkg::CRED_W-1:0] init_credit,
  input  rd_link_pkg::ar_pkt_t           user_ar,
  input  logic                           user_arvalid,
  output logic                           user_arready,
  input  logic                           credit_return,
  output logic                           tx_push,
  output rd_link_pkg::ar_pkt_t           tx_pkt
);
  import rd_link_pkg::*;

  ar_pkt_t           hold_pkt;
  logic              hold_valid;
  logic [CRED_W-1:0] cred;
  logic              cred_in;
  logic              accept;
  logic              send;

  // Credits from the far side only count while the link is up
  assign cred_in      = link_up && credit_return;
  assign user_arready = link_up && !hold_valid;
  assign accept       = user_arvalid && user_arready;
  assign send         = link_up && hold_valid && (cred != '0);

  assign tx_push = send;
  assign tx_pkt  = hold_pkt;

  always_ff @(posedge clk_wr) begin
    if (accept) begin
      hold_pkt <= user_ar;
    end
  end

  ////////////////////////////////////////
  // Holding register state
  ////////////////////////////////////////

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      hold_valid <= 1'b0;
    end else if (!link_up) begin
      hold_valid <= 1'b0;
    end else if (accept) begin
      hold_valid <= 1'b1;
    end else if (send) begin
      hold_valid <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // Far-side credit count
  ////////////////////////////////////////

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      cred <= '0;
    end else if (!link_up) begin
      cred <= init_credit;
    end else begin
      case ({cred_in, send})
        2'b10:   cred <= cred + CRED_W'(1);
        2'b01:   cred <= cred - CRED_W'(1);
        // Return and send in one cycle cancel out
        default: cred <= cred;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/phy_word_map.sv
`default_nettype none

module phy_word_map (
  input  logic                          tx_push,
  input  rd_link_pkg::ar_pkt_t          tx_pkt,
  input  logic                          r_credit,
  input  logic [rd_link_pkg::PHY_W-1:0] rx_phy0,
  output logic [rd_link_pkg::PHY_W-1:0] tx_phy0,
  output logic                          rx_push,
  output rd_link_pkg::r_pkt_t           rx_pkt,
  output logic                          ar_credit
);
  import rd_link_pkg::*;

  ////////////////////////////////////////
  // Outgoing word
  ////////////////////////////////////////

  always_comb begin
    // Unused bits stay zero
    tx_phy0 = '0;
    tx_phy0[TX_PUSH_BIT] = tx_push;
    tx_phy0[TX_AR_LSB +: $bits(ar_pkt_t)] = tx_pkt;
    tx_phy0[TX_RCRED_BIT] = r_credit;
  end

  ////////////////////////////////////////
  // Incoming word
  ////////////////////////////////////////

  always_comb begin
    rx_push   = rx_phy0[RX_PUSH_BIT];
    rx_pkt    = rx_phy0[RX_R_LSB +: $bits(r_pkt_t)];
    ar_credit = rx_phy0[RX_ARCRED_BIT];
  end

endmodule

`default_nettype wire

//--- hw/rd_link_pkg.sv
`default_nettype none

package rd_link_pkg;

  ////////////////////////////////////////
  // Widths and sizes
  ////////////////////////////////////////

  localparam int PHY_W         = 80;
  localparam int ID_W          = 4;
  localparam int ADDR_W        = 32;
  localparam int DATA_W        = 32;
  localparam int CRED_W        = 8;
  localparam int RX_FIFO_DEPTH = 8;
  localparam int RX_PTR_W      = $clog2(RX_FIFO_DEPTH);
  localparam int DELAY_W       = 16;

  ////////////////////////////////////////
  // PHY word bit positions
  ////////////////////////////////////////

  // Outgoing word
  localparam int TX_PUSH_BIT   = 0;
  localparam int TX_AR_LSB     = 1;
  localparam int TX_RCRED_BIT  = 50;

  // Incoming word
  localparam int RX_PUSH_BIT   = 0;
  localparam int RX_R_LSB      = 1;
  localparam int RX_ARCRED_BIT = 40;

  ////////////////////////////////////////
  // Packets and states
  ////////////////////////////////////////

  // AR request of 49 bits with addr at the bottom
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [2:0]        size;
    logic [7:0]        len;
    logic [1:0]        burst;
    logic [ADDR_W-1:0] addr;
  } ar_pkt_t;

  // R packet of 39 bits with data at the bottom
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic              last;
    logic [1:0]        resp;
    logic [DATA_W-1:0] data;
  } r_pkt_t;

  typedef enum logic [1:0] {
    OFFLINE,
    COUNTING,
    ONLINE
  } sync_state_t;

endpackage

`default_nettype wire

//--- sources.f
hw/rd_link_pkg.sv
hw/link_online_sync.sv
hw/ll_tx_channel.sv
hw/ll_rx_channel.sv
hw/phy_word_map.sv
hw/axi_rd_packet_master_top.sv
dv/link_checker.sv
dv/tb_top.sv
